//--- sim.f
src/fetch_isa_pkg.sv
src/fetch_cfg_pkg.sv
src/jump_scanner.sv
src/fifo_level_tracker.sv
src/fetch_sequencer.sv
src/instruction_fetch.sv
sim/instruction_fetch_props.sv
sim/instruction_fetch_tb.sv

//--- Makefile
TOP := instruction_fetch_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f $(wildcard src/*.sv sim/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- sim/instruction_fetch_tb.sv
`default_nettype none

module instruction_fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import fetch_isa_pkg::*;
	import fetch_cfg_pkg::*;

	// Five tests of under 100 cycles each, with a fourfold margin.
	localparam int TEST_COUNT = 5;
	localparam int TEST_CYCLE_LIMIT = 100;
	localparam int TIMEOUT_CYCLES = 4 * TEST_COUNT * TEST_CYCLE_LIMIT;

	// Extended opcode words with the prefix in bits 15 to 11 and the sub-opcode below it.
	localparam instr_word_t DIRECT_JUMP_WORD = {5'b11111, 3'b010, 8'h00};
	localparam instr_word_t INDIRECT_JUMP_WORD = {5'b11111, 3'b011, 8'h04};
	localparam instr_word_t CALL_WORD = {5'b11111, 3'b110, 8'h20};

	logic main_clk;
	logic rst;
	jump_cmd_t jump;
	logic fetch_ack;
	line_data_t line_data;
	fifo_count_t size_after_read;
	fetch_req_t fetch_req;
	logic performing_jump;
	fifo_count_t fifo_size;
	fifo_count_t fifo_size_next;

	logic [31:0] lcg_state = 32'h1ecd;
	int cycle_count = 0;
	int check_count = 0;
	int error_count = 0;
	int test_count = 0;
	int test_start_errors = 0;
	string test_name;

	instruction_fetch #(
		.FIFO_DEPTH(16)
	) u_instruction_fetch (
		.main_clk(main_clk),
		.rst(rst),
		.jump(jump),
		.fetch_ack(fetch_ack),
		.line_data(line_data),
		.size_after_read(size_after_read),
		.fetch_req(fetch_req),
		.performing_jump(performing_jump),
		.fifo_size(fifo_size),
		.fifo_size_next(fifo_size_next)
	);

	initial begin
		main_clk = 1'b0;
		forever #20 main_clk = ~main_clk;
	end

	always @(posedge main_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Plain words count up from the first one. None of them carries the extended prefix.
	function automatic line_data_t make_line(input instr_word_t first);
		line_data_t line;
		for (int i = 0; i < LINE_WORDS; i++) begin
			line[i] = first + instr_word_t'(i);
		end
		return line;
	endfunction

	task automatic compare_value(input string what, input int expected, input int actual);
		check_count++;
		assert (actual == expected) else begin
			$display("Fail %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected,
				actual);
			error_count++;
		end
	endtask

	task automatic check_condition(input bit condition, input string problem);
		check_count++;
		assert (condition) else begin
			$display("%s: %s", test_name, problem);
			error_count++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errors = error_count;
		test_count++;
	endtask

	task automatic end_test();
		if (error_count == test_start_errors) begin
			$display("%s: ok", test_name);
		end else begin
			$display("%s: %0d errors", test_name, error_count - test_start_errors);
		end
	endtask

	task automatic apply_reset(input fifo_count_t level);
		@(posedge main_clk);
		rst <= 1'b1;
		jump <= '0;
		fetch_ack <= 1'b0;
		size_after_read <= level;
		repeat (2) @(posedge main_clk);
		rst <= 1'b0;
	endtask

	task automatic wait_request(input int limit, output bit seen);
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(negedge main_clk);
			seen = fetch_req.request;
		end
	endtask

	// Memory model. The ack comes one to four cycles after the call.
	task automatic serve_line(input line_data_t data, output fifo_count_t size_on_ack);
		int delay;
		lcg_state = lcg_next(lcg_state);
		delay = 1 + int'(lcg_state[17:16]);
		repeat (delay) @(posedge main_clk);
		fetch_ack <= 1'b1;
		line_data <= data;
		@(negedge main_clk);
		size_on_ack = fifo_size_next;
		@(posedge main_clk);
		fetch_ack <= 1'b0;
	endtask

	task automatic send_redirect(input logic [31:0] target);
		jump_cmd_t cmd;
		cmd.redirect = 1'b1;
		cmd.target = target;
		@(posedge main_clk);
		jump <= cmd;
		@(negedge main_clk);
		check_condition(performing_jump, "performing_jump low during the redirect pulse");
		compare_value("fifo_size_next in pulse", 0, int'(fifo_size_next));
		@(posedge main_clk);
		jump <= '0;
	endtask

	task automatic test_reset_fetch();
		bit seen;
		fifo_count_t size_on_ack;
		begin_test("reset_fetch");
		apply_reset(5'd0);
		wait_request(4, seen);
		check_condition(seen, "no fetch request after reset");
		compare_value("first address", 0, int'(fetch_req.address));
		serve_line(make_line(16'h2100), size_on_ack);
		compare_value("fifo_size_next on ack", 8, int'(size_on_ack));
		@(negedge main_clk);
		compare_value("fifo_size after ack", 8, int'(fifo_size));
		check_condition(!fetch_req.request, "request still high after an accepted ack");
		wait_request(4, seen);
		check_condition(seen, "no second fetch request");
		compare_value("second address", 16, int'(fetch_req.address));
		end_test();
	endtask

	task automatic test_back_pressure();
		bit seen;
		begin_test("back_pressure");
		apply_reset(5'd12);
		wait_request(10, seen);
		check_condition(!seen, "request rose although the line does not fit");
		@(posedge main_clk);
		size_after_read <= 5'd8;
		wait_request(4, seen);
		check_condition(seen, "no request once the line fits");
		compare_value("address", 0, int'(fetch_req.address));
		end_test();
	endtask

	task automatic test_jump_stop();
		bit seen;
		fifo_count_t size_on_ack;
		line_data_t line;
		begin_test("jump_stop");
		apply_reset(5'd0);
		wait_request(4, seen);
		check_condition(seen, "no fetch request after reset");
		line = make_line(16'h2200);
		line[5] = DIRECT_JUMP_WORD;
		serve_line(line, size_on_ack);
		compare_value("fifo_size_next on ack", 8, int'(size_on_ack));
		wait_request(20, seen);
		check_condition(!seen, "fetching went on past a jump");
		end_test();
	endtask

	// Starts from the wait state that test_jump_stop leaves behind.
	task automatic test_redirect_idle();
		bit seen;
		fifo_count_t size_on_ack;
		line_data_t line;
		begin_test("redirect_idle");
		@(posedge main_clk);
		size_after_read <= 5'd6;
		send_redirect(32'h0000_0107);
		@(negedge main_clk);
		check_condition(fetch_req.request, "no request the cycle after the redirect");
		compare_value("target address", 32'h106, int'(fetch_req.address));
		line = make_line(16'h2300);
		line[1] = INDIRECT_JUMP_WORD;
		serve_line(line, size_on_ack);
		// Six words stay queued and offset 3 returns five more.
		compare_value("fifo_size_next on ack", 11, int'(size_on_ack));
		wait_request(4, seen);
		check_condition(seen, "a jump below the offset stopped fetching");
		compare_value("next address", 32'h110, int'(fetch_req.address));
		end_test();
	endtask

	task automatic test_redirect_busy();
		bit seen;
		fifo_count_t size_on_ack;
		line_data_t line;
		begin_test("redirect_busy");
		apply_reset(5'd4);
		wait_request(4, seen);
		check_condition(seen, "no fetch request after reset");
		send_redirect(32'h0000_0240);
		@(negedge main_clk);
		check_condition(performing_jump, "redirect not held while the fetch is in flight");
		check_condition(fetch_req.request, "request dropped before its ack");
		line = make_line(16'h2400);
		line[2] = CALL_WORD;
		serve_line(line, size_on_ack);
		compare_value("fifo_size_next on stale ack", 0, int'(size_on_ack));
		@(negedge main_clk);
		check_condition(fetch_req.request, "request not held after the stale ack");
		check_condition(!performing_jump, "redirect still active after the stale ack");
		compare_value("target address", 32'h240, int'(fetch_req.address));
		serve_line(make_line(16'h2500), size_on_ack);
		compare_value("fifo_size_next on new ack", 12, int'(size_on_ack));
		end_test();
	endtask

	initial begin
		rst = 1'b1;
		jump = '0;
		fetch_ack = 1'b0;
		line_data = '0;
		size_after_read = '0;
		test_reset_fetch();
		test_back_pressure();
		test_jump_stop();
		test_redirect_idle();
		test_redirect_busy();
		$display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/instruction_fetch_props.sv
`default_nettype none

module instruction_fetch_props (
	input logic main_clk,
	input logic rst,
	input fetch_cfg_pkg::fetch_req_t fetch_req,
	input logic fetch_ack,
	input logic performing_jump,
	input fetch_cfg_pkg::fifo_count_t fifo_size_next
);
	timeunit 1ns;
	timeprecision 1ps;

	// Instruction words are halfword aligned.
	address_aligned: assert property (@(posedge main_clk) disable iff (rst)
		!fetch_req.address[0])
		else $error("Fetch address has bit 0 set");

	// The memory handshake is a level request that only the ack may drop.
	request_held: assert property (@(posedge main_clk) disable iff (rst)
		fetch_req.request && !fetch_ack |=> fetch_req.request)
		else $error("Fetch request dropped before its ack");

	flush_on_jump: assert property (@(posedge main_clk) disable iff (rst)
		performing_jump |-> fifo_size_next == '0)
		else $error("FIFO occupancy not cleared during a redirect");

endmodule

bind instruction_fetch instruction_fetch_props u_instruction_fetch_props (
	.main_clk(main_clk),
	.rst(rst),
	.fetch_req(fetch_req),
	.fetch_ack(fetch_ack),
	.performing_jump(performing_jump),
	.fifo_size_next(fifo_size_next)
);

`default_nettype wire

//--- src/instruction_fetch.sv
`default_nettype none

module instruction_fetch #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic main_clk,
	input  logic rst,
	input  fetch_cfg_pkg::jump_cmd_t jump,
	input  logic fetch_ack,
	input  fetch_cfg_pkg::line_data_t line_data,
	input  fetch_cfg_pkg::fifo_count_t size_after_read,
	output fetch_cfg_pkg::fetch_req_t fetch_req,
	output logic performing_jump,
	output fetch_cfg_pkg::fifo_count_t fifo_size,
	output fetch_cfg_pkg::fifo_count_t fifo_size_next
);
	import fetch_cfg_pkg::*;

	word_count_t word_count;
	word_offset_t offset;
	logic line_accepted;
	logic has_room;
	logic jump_found;

	fetch_sequencer u_fetch_sequencer (
		.main_clk(main_clk),
		.rst(rst),
		.jump(jump),
		.fetch_ack(fetch_ack),
		.has_room(has_room),
		.jump_found(jump_found),
		.fetch_req(fetch_req),
		.word_count(word_count),
		.offset(offset),
		.line_accepted(line_accepted),
		.performing_jump(performing_jump)
	);

	jump_scanner u_jump_scanner (
		.line_data(line_data),
		.offset(offset),
		.jump_found(jump_found)
	);

	fifo_level_tracker #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo_level_tracker (
		.main_clk(main_clk),
		.rst(rst),
		.size_after_read(size_after_read),
		.word_count(word_count),
		.line_accepted(line_accepted),
		.performing_jump(performing_jump),
		.has_room(has_room),
		.fifo_size(fifo_size),
		.fifo_size_next(fifo_size_next)
	);

endmodule

`default_nettype wire

//--- src/fetch_sequencer.sv
`default_nettype none

module fetch_sequencer (
	input  logic main_clk,
	input  logic rst,
	input  fetch_cfg_pkg::jump_cmd_t jump,
	input  logic fetch_ack,
	input  logic has_room,
	input  logic jump_found,
	output fetch_cfg_pkg::fetch_req_t fetch_req,
	output fetch_cfg_pkg::word_count_t word_count,
	output fetch_cfg_pkg::word_offset_t offset,
	output logic line_accepted,
	output logic performing_jump
);
	import fetch_cfg_pkg::*;

	seq_state_t state;
	seq_state_t state_next;
	fetch_addr_t fetch_addr;
	fetch_addr_t fetch_addr_next;
	logic redirect_pending;
	logic redirect_pending_next;
	fetch_addr_t saved_target;
	fetch_addr_t redirect_target;

	// The line returns the words from the offset up to its end.
	assign offset = fetch_addr[3:1];
	assign word_count = word_count_t'(LINE_WORDS) - word_count_t'(offset);

	assign performing_jump = jump.redirect | redirect_pending;

	// A pulse in the current cycle overrides a target saved earlier.
	assign redirect_target = jump.redirect ? {jump.target[25:1], 1'b0} : saved_target;

	assign line_accepted = (state == REQUESTING) && fetch_ack && !performing_jump;

	assign fetch_req = '{request: (state == REQUESTING), address: fetch_addr};

	always_comb begin
		state_next = state;
		fetch_addr_next = fetch_addr;
		redirect_pending_next = redirect_pending;
		unique case (state)
			IDLE: begin
				if (jump.redirect) begin
					fetch_addr_next = redirect_target;
					state_next = REQUESTING;
				end else if (has_room) begin
					state_next = REQUESTING;
				end
			end
			WAIT_JUMP: begin
				// Only the core can restart fetching past a jump.
				if (jump.redirect) begin
					fetch_addr_next = redirect_target;
					state_next = REQUESTING;
				end
			end
			REQUESTING: begin
				if (line_accepted) begin
					fetch_addr_next = fetch_addr + fetch_addr_t'({word_count, 1'b0});
					state_next = jump_found ? WAIT_JUMP : IDLE;
				end else if (fetch_ack) begin
					// The line belongs to the old path. Refetch at the target at once.
					fetch_addr_next = redirect_target;
					redirect_pending_next = 1'b0;
				end else if (jump.redirect) begin
					redirect_pending_next = 1'b1;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge main_clk) begin
		if (rst) begin
			state <= IDLE;
			fetch_addr <= '0;
			redirect_pending <= 1'b0;
		end else begin
			state <= state_next;
			fetch_addr <= fetch_addr_next;
			redirect_pending <= redirect_pending_next;
		end
	end

	// Holds the target while the outstanding fetch drains.
	always_ff @(posedge main_clk) begin
		if (jump.redirect) begin
			saved_target <= {jump.target[25:1], 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- src/fifo_level_tracker.sv
`default_nettype none

module fifo_level_tracker #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic main_clk,
	input  logic rst,
	input  fetch_cfg_pkg::fifo_count_t size_after_read,
	input  fetch_cfg_pkg::word_count_t word_count,
	input  logic line_accepted,
	input  logic performing_jump,
	output logic has_room,
	output fetch_cfg_pkg::fifo_count_t fifo_size,
	output fetch_cfg_pkg::fifo_count_t fifo_size_next
);
	import fetch_cfg_pkg::*;

	// One bit wider than the occupancy so the sum cannot wrap.
	logic [5:0] size_with_line;

	assign size_with_line = 6'(size_after_read) + 6'(word_count);

	// The whole returning run has to fit behind what stays in the FIFO.
	assign has_room = size_with_line <= 6'(FIFO_DEPTH);

	always_comb begin
		if (performing_jump) begin
			// A redirect flushes everything queued from the old path.
			fifo_size_next = '0;
		end else if (line_accepted) begin
			fifo_size_next = fifo_count_t'(size_with_line);
		end else begin
			fifo_size_next = size_after_read;
		end
	end

	always_ff @(posedge main_clk) begin
		if (rst) begin
			fifo_size <= '0;
		end else begin
			fifo_size <= fifo_size_next;
		end
	end

endmodule

`default_nettype wire

//--- src/jump_scanner.sv
`default_nettype none

module jump_scanner (
	input  fetch_cfg_pkg::line_data_t line_data,
	input  fetch_cfg_pkg::word_offset_t offset,
	output logic jump_found
);
	import fetch_isa_pkg::*;
	import fetch_cfg_pkg::*;

	logic [LINE_WORDS-1:0] word_hit;

	always_comb begin
		opcode_prefix_t prefix;
		sub_opcode_t sub_op;
		for (int i = 0; i < LINE_WORDS; i++) begin
			prefix = line_data[i][15:11];
			sub_op = line_data[i][10:8];
			word_hit[i] = (prefix == JUMP_PREFIX) &&
				(sub_op == JUMP_OP_DIRECT ||
				 sub_op == JUMP_OP_INDIRECT ||
				 sub_op == JUMP_OP_CALL);
			// Words below the fetch offset are not part of the returned run.
			if (word_offset_t'(i) < offset) begin
				word_hit[i] = 1'b0;
			end
		end
	end

	assign jump_found = |word_hit;

endmodule

`default_nettype wire

//--- src/fetch_cfg_pkg.sv
`default_nettype none

package fetch_cfg_pkg;

	// One memory line is 16 bytes.
	localparam int LINE_WORDS = 8;

	// Byte address; instruction words are aligned so bit 0 stays clear.
	typedef logic [25:0] fetch_addr_t;
	typedef logic [2:0] word_offset_t;
	typedef logic [3:0] word_count_t;
	typedef logic [4:0] fifo_count_t;
	typedef logic [31:0] jump_target_t;

	// Word 0 sits at the lowest address of the line.
	typedef fetch_isa_pkg::instr_word_t [LINE_WORDS-1:0] line_data_t;

	typedef struct packed {
		logic request;
		fetch_addr_t address;
	} fetch_req_t;

	// Only the low 26 bits of the target reach the fetch address.
	typedef struct packed {
		logic redirect;
		jump_target_t target;
	} jump_cmd_t;

	typedef enum logic [1:0] {
		IDLE,
		REQUESTING,
		WAIT_JUMP
	} seq_state_t;

endpackage

`default_nettype wire

//--- src/fetch_isa_pkg.sv
`default_nettype none

package fetch_isa_pkg;

	typedef logic [15:0] instr_word_t;

	// Fields of an extended opcode word.
	typedef logic [4:0] opcode_prefix_t;
	typedef logic [2:0] sub_opcode_t;

	// An all ones prefix in bits 15 to 11 selects the extended opcode space.
	localparam opcode_prefix_t JUMP_PREFIX = 5'h1f;

	// Extended sub-opcodes in bits 10 to 8 that change the program flow.
	localparam sub_opcode_t JUMP_OP_DIRECT = 3'b010;
	localparam sub_opcode_t JUMP_OP_INDIRECT = 3'b011;
	localparam sub_opcode_t JUMP_OP_CALL = 3'b110;

endpackage

`default_nettype wire
